// File: verilog/debug_pkg.sv
// Shared widths, encodings and port structs for the debug unit; imported by every RTL module
`default_nettype none

package debug_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and PC constants
  ////////////////////////////////////////////////////////////////////////////

  // Data and PC width
  localparam int unsigned XLEN = 32;

  // Reset vector
  localparam logic [XLEN-1:0] PC_INIT = 32'h8000_0000;
  // One instruction per retire
  localparam logic [XLEN-1:0] PC_STEP = 32'd4;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  // Debug register map
  typedef enum logic [1:0] {
    DBG_CTRL   = 2'd0,  // bit0 step enable, bit1 breakpoint enable
    DBG_HIT    = 2'd1,  // bit0 step hit, bit1 breakpoint hit
    DBG_BPADDR = 2'd2,
    DBG_PC     = 2'd3   // read only
  } dbg_addr_e;

  // Core run state
  typedef enum logic [1:0] {
    RUN    = 2'd0,
    STEP   = 2'd1,
    HALTED = 2'd2
  } dbg_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Port and register structs
  ////////////////////////////////////////////////////////////////////////////

  // Debugger request, XLEN+4 bits
  typedef struct packed {
    logic            strb;
    logic            we;
    dbg_addr_e       addr;
    logic [XLEN-1:0] wdata;
  } dbg_req_t;

  // Response, ack one cycle after strobe
  typedef struct packed {
    logic            ack;
    logic [XLEN-1:0] rdata;
  } dbg_rsp_t;

  // Field order follows register bit order, LSB last
  typedef struct packed {
    logic bp_en;
    logic step_en;
  } dbg_ctrl_t;

  // Hit event and hit status share one layout
  typedef struct packed {
    logic bp_hit;
    logic step_hit;
  } dbg_hit_t;

endpackage

`default_nettype wire

// File: verilog/debug_fsm.sv
// Run, step and halt control of the core; instantiated once in the debug unit top level
`timescale 1ns/100ps
`default_nettype none

module debug_fsm import debug_pkg::*; (
  input  wire             HCLK,
  input  wire             reset_i,
  input  wire             dbg_stall_i,
  input  wire  dbg_ctrl_t ctrl_i,
  input  wire  dbg_hit_t  hit_status_i,
  input  wire             bp_match_i,
  output logic            retire_o,
  output dbg_hit_t        hit_set_o,
  output logic            cpu_stall_o,
  output logic            dbg_bp_o
);

  dbg_state_e state_q;
  dbg_state_e state_d;
  dbg_hit_t   hit_q;
  logic       bp_stop;

  // Armed breakpoint sitting on current PC
  assign bp_stop = ctrl_i.bp_en && bp_match_i;

  ////////////////////////////////////////////////////////////////////////////
  // Next state and retire decision
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    retire_o  = 1'b0;
    hit_set_o = '0;

    case (state_q)
      RUN, STEP: begin
        if (dbg_stall_i) begin
          // External stall first, no hit reported
          state_d  = HALTED;
          // Never retire past an armed breakpoint
          retire_o = !bp_stop;
        end else if (bp_stop) begin
          // Stop before the breakpoint instruction
          state_d          = HALTED;
          hit_set_o.bp_hit = 1'b1;
        end else begin
          retire_o = 1'b1;
          // STEP always halts after its one instruction
          if (state_q == STEP || ctrl_i.step_en) begin
            state_d            = HALTED;
            hit_set_o.step_hit = 1'b1;
          end
        end
      end

      HALTED: begin
        // Stay until stall dropped and status cleared
        if (!dbg_stall_i && hit_status_i == '0) begin
          state_d = ctrl_i.step_en ? STEP : RUN;
        end
      end

      default: begin
        state_d = RUN;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // State and hit event registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK) begin
    if (reset_i) begin
      state_q <= RUN;
      hit_q   <= '0;
    end else begin
      state_q <= state_d;
      // Lines up with the status update in the register bank
      hit_q   <= hit_set_o;
    end
  end

  // Core frozen only while halted
  assign cpu_stall_o = (state_q == HALTED);

  // Breakpoint pulse to debugger on any hit
  assign dbg_bp_o = |hit_q;

endmodule

`default_nettype wire

// File: verilog/pc_sequencer.sv
// Program counter model of the core with breakpoint compare; instantiated in the debug unit top
`timescale 1ns/100ps
`default_nettype none

module pc_sequencer import debug_pkg::*; (
  input  wire              HCLK,
  input  wire              reset_i,
  input  wire              retire_i,
  input  wire  [XLEN-1:0]  bp_addr_i,
  output logic [XLEN-1:0]  pc_o,
  output logic             bp_match_o
);

  logic [XLEN-1:0] pc_q;

  ////////////////////////////////////////////////////////////////////////////
  // PC counter
  ////////////////////////////////////////////////////////////////////////////

  // Start at reset vector, one step per retired instruction
  always_ff @(posedge HCLK) begin
    if (reset_i) begin
      pc_q <= PC_INIT;
    end else if (retire_i) begin
      pc_q <= pc_q + PC_STEP;
    end
  end

  assign pc_o = pc_q;

  ////////////////////////////////////////////////////////////////////////////
  // Breakpoint compare
  ////////////////////////////////////////////////////////////////////////////

  // Raw address match, enable applied in the FSM
  assign bp_match_o = (pc_q == bp_addr_i);

endmodule

`default_nettype wire

// File: verilog/debug_regs.sv
// Debugger-visible register bank with strobe/ack port; instantiated in the debug unit top
`timescale 1ns/100ps
`default_nettype none

module debug_regs import debug_pkg::*; (
  input  wire              HCLK,
  input  wire              reset_i,
  input  wire  dbg_req_t   dbg_req_i,
  input  wire  dbg_hit_t   hit_set_i,
  input  wire  [XLEN-1:0]  pc_i,
  output dbg_rsp_t         dbg_rsp_o,
  output dbg_ctrl_t        ctrl_o,
  output dbg_hit_t         hit_status_o,
  output logic [XLEN-1:0]  bp_addr_o
);

  dbg_ctrl_t       ctrl_q;
  dbg_hit_t        hit_q;
  dbg_hit_t        hit_d;
  logic [XLEN-1:0] bp_addr_q;
  logic [XLEN-1:0] rdata_d;
  logic [XLEN-1:0] rdata_q;
  logic            ack_q;
  logic            wr_en;
  logic            rd_en;

  // Request decode
  assign wr_en = dbg_req_i.strb && dbg_req_i.we;
  assign rd_en = dbg_req_i.strb && !dbg_req_i.we;

  ////////////////////////////////////////////////////////////////////////////
  // Writable registers
  ////////////////////////////////////////////////////////////////////////////

  // Control and breakpoint address
  always_ff @(posedge HCLK) begin
    if (reset_i) begin
      ctrl_q    <= '0;
      bp_addr_q <= '0;
    end else if (wr_en) begin
      case (dbg_req_i.addr)
        DBG_CTRL:   ctrl_q    <= dbg_ctrl_t'(dbg_req_i.wdata[$bits(dbg_ctrl_t)-1:0]);
        DBG_BPADDR: bp_addr_q <= dbg_req_i.wdata;
        // HIT handled below, PC not writable
        default: ;
      endcase
    end
  end

  // Hit status, any write clears
  always_comb begin
    hit_d = hit_q;
    if (wr_en && dbg_req_i.addr == DBG_HIT) begin
      hit_d = '0;
    end
    // New event beats a clear in the same cycle
    hit_d = hit_d | hit_set_i;
  end

  always_ff @(posedge HCLK) begin
    if (reset_i) begin
      hit_q <= '0;
    end else begin
      hit_q <= hit_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read path and acknowledge
  ////////////////////////////////////////////////////////////////////////////

  // Register mux, status fields zero extended
  always_comb begin
    case (dbg_req_i.addr)
      DBG_CTRL:   rdata_d = XLEN'(ctrl_q);
      DBG_HIT:    rdata_d = XLEN'(hit_q);
      DBG_BPADDR: rdata_d = bp_addr_q;
      default:    rdata_d = pc_i;
    endcase
  end

  // Read data sampled at the strobe edge
  always_ff @(posedge HCLK) begin
    if (rd_en) begin
      rdata_q <= rdata_d;
    end
  end

  // One-cycle ack for reads and writes alike
  always_ff @(posedge HCLK) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= dbg_req_i.strb;
    end
  end

  assign dbg_rsp_o    = '{ack: ack_q, rdata: rdata_q};
  assign ctrl_o       = ctrl_q;
  assign hit_status_o = hit_q;
  assign bp_addr_o    = bp_addr_q;

endmodule

`default_nettype wire

// File: verilog/debug_unit_top.sv
// Debug unit top level joining FSM, PC sequencer and register bank; the DUT of the testbench
`timescale 1ns/100ps
`default_nettype none

module debug_unit_top import debug_pkg::*; (
  input  wire              HCLK,
  input  wire              reset_i,
  input  wire              dbg_stall_i,
  input  wire  dbg_req_t   dbg_req_i,
  output dbg_rsp_t         dbg_rsp_o,
  output logic             dbg_bp_o,
  output logic             cpu_stall_o,
  output logic [XLEN-1:0]  pc_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////////////////////////////////////////

  // From register bank
  dbg_ctrl_t       ctrl;
  dbg_hit_t        hit_status;
  logic [XLEN-1:0] bp_addr;

  // From sequencer
  logic            bp_match;

  // From FSM
  logic            retire;
  dbg_hit_t        hit_set;

  ////////////////////////////////////////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////////////////////////////////////////

  // Run and halt control
  debug_fsm fsm0 (
    .HCLK         (HCLK),
    .reset_i      (reset_i),
    .dbg_stall_i  (dbg_stall_i),
    .ctrl_i       (ctrl),
    .hit_status_i (hit_status),
    .bp_match_i   (bp_match),
    .retire_o     (retire),
    .hit_set_o    (hit_set),
    .cpu_stall_o  (cpu_stall_o),
    .dbg_bp_o     (dbg_bp_o)
  );

  // Core PC stand-in
  pc_sequencer seq0 (
    .HCLK       (HCLK),
    .reset_i    (reset_i),
    .retire_i   (retire),
    .bp_addr_i  (bp_addr),
    .pc_o       (pc_o),
    .bp_match_o (bp_match)
  );

  // Debugger register port
  debug_regs regs0 (
    .HCLK         (HCLK),
    .reset_i      (reset_i),
    .dbg_req_i    (dbg_req_i),
    .hit_set_i    (hit_set),
    .pc_i         (pc_o),
    .dbg_rsp_o    (dbg_rsp_o),
    .ctrl_o       (ctrl),
    .hit_status_o (hit_status),
    .bp_addr_o    (bp_addr)
  );

endmodule

`default_nettype wire

// File: tests/debug_unit_asserts.sv
// Concurrent checks on debug port and halt timing; bound into debug_unit_top by the testbench
`timescale 1ns/100ps
`default_nettype none

module debug_unit_asserts import debug_pkg::*; (
  input wire           HCLK,
  input wire           reset_i,
  input wire dbg_req_t req_i,
  input wire dbg_rsp_t rsp_i,
  input wire           bp_i,
  input wire           stall_i
);

  // Ack one cycle after every strobe
  ack_after_strb: assert property (@(posedge HCLK) disable iff (reset_i)
    req_i.strb |=> rsp_i.ack)
    else $error("ack missing one cycle after strobe");

  // No ack without a strobe the cycle before
  ack_has_strb: assert property (@(posedge HCLK) disable iff (reset_i)
    rsp_i.ack |-> $past(req_i.strb))
    else $error("ack without preceding strobe");

  // Debugger must not issue a request while ack is up
  no_strb_in_ack: assert property (@(posedge HCLK) disable iff (reset_i)
    rsp_i.ack |-> !req_i.strb)
    else $error("strobe during ack");

  // Hit pulse always followed by a held core
  bp_then_stall: assert property (@(posedge HCLK) disable iff (reset_i)
    bp_i |=> stall_i)
    else $error("breakpoint pulse not followed by cpu stall");

endmodule

`default_nettype wire

// File: tests/debug_unit_tb.sv
// Table-driven testbench for the debug unit; top module debug_unit_tb, sources listed in tb.f
`timescale 1ns/100ps
`default_nettype none

module debug_unit_tb import debug_pkg::*; ();

  localparam int CLK_HALF   = 10;
  localparam int DRIVE_DLY  = 2;
  localparam int ACK_LIMIT  = 4;
  localparam int HALT_LIMIT = 64;

  // Table operations
  typedef enum logic [2:0] {
    OP_WRITE,
    OP_READ,
    OP_STALL,
    OP_RELEASE,
    OP_WAIT_HALT,  // data[0] is the expected dbg_bp_o at the halt
    OP_IDLE,       // data is the cycle count
    OP_PC_GROW,    // PC must be above the model, then becomes the model
    OP_PINS        // exp[0] cpu_stall_o, exp[1] dbg_bp_o
  } op_e;

  // rel set means data counts instructions past the model PC
  typedef struct packed {
    op_e             op;
    dbg_addr_e       addr;
    logic            rel;
    logic [XLEN-1:0] data;
    logic [XLEN-1:0] exp;
  } entry_t;

  logic            HCLK;
  logic            reset_i;
  logic            dbg_stall_i;
  dbg_req_t        dbg_req_i;
  dbg_rsp_t        dbg_rsp_o;
  logic            dbg_bp_o;
  logic            cpu_stall_o;
  logic [XLEN-1:0] pc_o;

  entry_t          stim_q[$];
  logic [XLEN-1:0] model_pc;
  bit              table_ready = 1'b0;

  debug_unit_top dut0 (
    .HCLK        (HCLK),
    .reset_i     (reset_i),
    .dbg_stall_i (dbg_stall_i),
    .dbg_req_i   (dbg_req_i),
    .dbg_rsp_o   (dbg_rsp_o),
    .dbg_bp_o    (dbg_bp_o),
    .cpu_stall_o (cpu_stall_o),
    .pc_o        (pc_o)
  );

  bind debug_unit_top debug_unit_asserts asserts0 (
    .HCLK    (HCLK),
    .reset_i (reset_i),
    .req_i   (dbg_req_i),
    .rsp_i   (dbg_rsp_o),
    .bp_i    (dbg_bp_o),
    .stall_i (cpu_stall_o)
  );

  // 20 ns clock
  initial HCLK = 1'b0;
  always #CLK_HALF HCLK = ~HCLK;

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting and compares
  ////////////////////////////////////////////////////////////////////////////

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_rdata(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_hit(input dbg_hit_t got, input dbg_hit_t exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: hit status got %b expected %b", $time, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus and halt helpers
  ////////////////////////////////////////////////////////////////////////////

  // Drive point a little after the rising edge
  task automatic next_cycle();
    @(posedge HCLK);
    #DRIVE_DLY;
  endtask

  task automatic bus_access(input logic we, input dbg_addr_e addr,
                            input logic [XLEN-1:0] wdata, output logic [XLEN-1:0] rdata);
    int waited;
    dbg_req_i = '{strb: 1'b1, we: we, addr: addr, wdata: wdata};
    next_cycle();
    // One-cycle strobe
    dbg_req_i.strb = 1'b0;
    waited = 0;
    while (!dbg_rsp_o.ack) begin
      if (waited == ACK_LIMIT) begin
        fail_run("debug port gave no acknowledge");
      end
      next_cycle();
      waited++;
    end
    rdata = dbg_rsp_o.rdata;
    // Step past the ack cycle
    next_cycle();
  endtask

  task automatic wait_halt(input logic exp_bp);
    int waited;
    waited = 0;
    while (!cpu_stall_o) begin
      if (waited == HALT_LIMIT) begin
        fail_run("core did not halt within 64 cycles");
      end
      next_cycle();
      waited++;
    end
    // First halted cycle carries the hit pulse
    check_bit("dbg_bp_o", dbg_bp_o, exp_bp);
    if (exp_bp) begin
      // Hit pulse lasts a single cycle
      next_cycle();
      check_bit("dbg_bp_o", dbg_bp_o, 1'b0);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Table
  ////////////////////////////////////////////////////////////////////////////

  function automatic void add_entry(input op_e op, input dbg_addr_e addr, input logic rel,
                                    input logic [XLEN-1:0] data, input logic [XLEN-1:0] exp);
    stim_q.push_back('{op: op, addr: addr, rel: rel, data: data, exp: exp});
  endfunction

  function automatic void build_table();
    // Reset values
    add_entry(OP_PINS,      DBG_CTRL,   1'b0, 0, 0);
    add_entry(OP_READ,      DBG_CTRL,   1'b0, 0, 0);
    add_entry(OP_READ,      DBG_HIT,    1'b0, 0, 0);
    add_entry(OP_READ,      DBG_BPADDR, 1'b0, 0, 0);
    // External stall holds the PC
    add_entry(OP_STALL,     DBG_CTRL,   1'b0, 0, 0);
    add_entry(OP_WAIT_HALT, DBG_CTRL,   1'b0, 0, 0);
    add_entry(OP_PC_GROW,   DBG_PC,     1'b0, 0, 0);
    add_entry(OP_IDLE,      DBG_CTRL,   1'b0, 8, 0);
    add_entry(OP_READ,      DBG_PC,     1'b0, 0, 0);
    add_entry(OP_RELEASE,   DBG_CTRL,   1'b0, 0, 0);
    add_entry(OP_IDLE,      DBG_CTRL,   1'b0, 8, 0);
    add_entry(OP_PC_GROW,   DBG_PC,     1'b0, 0, 0);
    // Single step with the first step on stall release
    add_entry(OP_STALL,     DBG_CTRL,   1'b0, 0, 0);
    add_entry(OP_WAIT_HALT, DBG_CTRL,   1'b0, 0, 0);
    add_entry(OP_PC_GROW,   DBG_PC,     1'b0, 0, 0);
    add_entry(OP_WRITE,     DBG_CTRL,   1'b0, 1, 0);
    add_entry(OP_RELEASE,   DBG_CTRL,   1'b0, 0, 0);
    add_entry(OP_WAIT_HALT, DBG_CTRL,   1'b0, 1, 0);
    add_entry(OP_READ,      DBG_HIT,    1'b0, 0, 1);
    add_entry(OP_READ,      DBG_PC,     1'b0, 0, 1);
    // Later steps released by clearing HIT
    for (int n = 0; n < 5; n++) begin
      add_entry(OP_WRITE,     DBG_HIT,  1'b0, 0, 0);
      add_entry(OP_WAIT_HALT, DBG_CTRL, 1'b0, 1, 0);
      add_entry(OP_READ,      DBG_HIT,  1'b0, 0, 1);
      add_entry(OP_READ,      DBG_PC,   1'b0, 0, 1);
    end
    // Breakpoint twelve instructions ahead
    add_entry(OP_WRITE,     DBG_BPADDR, 1'b1, 12, 0);
    add_entry(OP_WRITE,     DBG_CTRL,   1'b0, 2, 0);
    add_entry(OP_WRITE,     DBG_HIT,    1'b0, 0, 0);
    add_entry(OP_WAIT_HALT, DBG_CTRL,   1'b0, 1, 0);
    add_entry(OP_READ,      DBG_PC,     1'b0, 0, 12);
    add_entry(OP_READ,      DBG_HIT,    1'b0, 0, 2);
    // Register read back, PC write ignored, clear and run
    add_entry(OP_READ,      DBG_CTRL,   1'b0, 0, 2);
    add_entry(OP_WRITE,     DBG_CTRL,   1'b0, 3, 0);
    add_entry(OP_READ,      DBG_CTRL,   1'b0, 0, 3);
    add_entry(OP_WRITE,     DBG_CTRL,   1'b0, 0, 0);
    add_entry(OP_READ,      DBG_CTRL,   1'b0, 0, 0);
    add_entry(OP_WRITE,     DBG_BPADDR, 1'b0, 32'h1234_5678, 0);
    add_entry(OP_READ,      DBG_BPADDR, 1'b0, 0, 32'h1234_5678);
    add_entry(OP_WRITE,     DBG_PC,     1'b0, 32'hdead_beec, 0);
    add_entry(OP_READ,      DBG_PC,     1'b0, 0, 0);
    add_entry(OP_WRITE,     DBG_HIT,    1'b0, 3, 0);
    add_entry(OP_READ,      DBG_HIT,    1'b0, 0, 0);
    add_entry(OP_PINS,      DBG_CTRL,   1'b0, 0, 0);
    add_entry(OP_PC_GROW,   DBG_PC,     1'b0, 0, 0);
  endfunction

  task automatic run_entry(input entry_t e);
    logic [XLEN-1:0] rd_val;
    logic [XLEN-1:0] exp;
    dbg_addr_e       addr;
    addr = e.addr;
    case (e.op)
      OP_WRITE: begin
        exp = e.rel ? model_pc + e.data * PC_STEP : e.data;
        bus_access(1'b1, addr, exp, rd_val);
      end
      OP_READ: begin
        bus_access(1'b0, addr, '0, rd_val);
        if (addr == DBG_HIT) begin
          check_hit(dbg_hit_t'(rd_val[1:0]), dbg_hit_t'(e.exp[1:0]));
        end else if (addr == DBG_PC) begin
          // PC reads happen while halted, so the port must agree
          exp = model_pc + e.exp * PC_STEP;
          check_rdata("pc read", rd_val, exp);
          check_rdata("pc_o", pc_o, exp);
          model_pc = exp;
        end else begin
          check_rdata(addr.name(), rd_val, e.exp);
        end
      end
      OP_STALL: begin
        dbg_stall_i = 1'b1;
        next_cycle();
      end
      OP_RELEASE: begin
        dbg_stall_i = 1'b0;
        next_cycle();
      end
      OP_WAIT_HALT: wait_halt(e.data[0]);
      OP_IDLE: repeat (e.data) next_cycle();
      OP_PC_GROW: begin
        bus_access(1'b0, DBG_PC, '0, rd_val);
        if (rd_val <= model_pc) begin
          fail_run($sformatf("mismatch at %0t: pc got %h expected above %h",
                             $time, rd_val, model_pc));
        end
        model_pc = rd_val;
      end
      OP_PINS: begin
        check_bit("cpu_stall_o", cpu_stall_o, e.exp[0]);
        check_bit("dbg_bp_o", dbg_bp_o, e.exp[1]);
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    dbg_stall_i = 1'b0;
    dbg_req_i   = '0;
    reset_i     = 1'b1;
    model_pc    = PC_INIT;
    build_table();
    table_ready = 1'b1;
    repeat (10) @(posedge HCLK);
    #DRIVE_DLY;
    reset_i = 1'b0;
    foreach (stim_q[i]) begin
      run_entry(stim_q[i]);
    end
    $display("RESULT: PASS");
    $finish;
  end

  // Budget of 100 cycles per table entry
  initial begin
    wait (table_ready);
    repeat (stim_q.size() * 100) @(posedge HCLK);
    fail_run("watchdog expired before the table finished");
  end

endmodule

`default_nettype wire

// File: tb.f
verilog/debug_pkg.sv
verilog/debug_fsm.sv
verilog/pc_sequencer.sv
verilog/debug_regs.sv
verilog/debug_unit_top.sv
tests/debug_unit_asserts.sv
tests/debug_unit_tb.sv

// File: Makefile
TOP := debug_unit_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP)

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir
